//--- rtl/uart_byte_fifo.sv
// UART byte FIFO: first-word-fall-through storage for either direction.
`default_nettype none

module uart_byte_fifo
#(
    parameter int DEPTH = 4
)
(
    input  wire logic       clk_50,
    input  wire logic       rst,
    input  wire logic       push,
    input  wire logic [7:0] push_data,
    input  wire logic       pop,
    output logic [7:0]      head,
    output logic            empty,
    output logic            full
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push_ok;

    assign push_ok = push && !full; // a push into a full FIFO is lost.
    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk_50)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // the caller only pops when the FIFO holds data.
            if (push_ok && !pop)
                count <= count + 1'b1;
            else if (pop && !push_ok)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_core.sv
// UART core: sample tick, transmit and receive framers and their byte FIFOs.
`default_nettype none

module uart_core
#(
    parameter int SAMPLE_DIV = uart_pkg::default_sample_div,
    parameter int TX_DEPTH   = 4,
    parameter int RX_DEPTH   = 8
)
(
    input  wire logic       clk_50,
    input  wire logic       rst,
    input  wire logic       wr_en,
    input  wire logic [7:0] wr_data,
    output logic            tx_full,
    input  wire logic       rd_en,
    output logic [7:0]      rd_data,
    output logic            rx_empty,
    output logic [7:0]      frame_errors,
    output logic            uart_tx,
    input  wire logic       uart_rx
);

    logic       sample_en;
    logic [7:0] tx_head;
    logic       tx_fifo_empty;
    logic       tx_pop;
    logic       rx_vld;
    logic [7:0] rx_data;
    logic       rx_frame_error;

    uart_sample_tick #(.SAMPLE_DIV(SAMPLE_DIV)) i_sample_tick
    (
        .clk_50    (clk_50),
        .rst       (rst),
        .sample_en (sample_en)
    );

    uart_byte_fifo #(.DEPTH(TX_DEPTH)) i_tx_fifo
    (
        .clk_50    (clk_50),
        .rst       (rst),
        .push      (wr_en),
        .push_data (wr_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .empty     (tx_fifo_empty),
        .full      (tx_full)
    );

    uart_tx_framer i_tx_framer
    (
        .clk_50    (clk_50),
        .rst       (rst),
        .sample_en (sample_en),
        .tx_empty  (tx_fifo_empty),
        .tx_byte   (tx_head),
        .tx_pop    (tx_pop),
        .uart_tx   (uart_tx)
    );

    uart_rx_framer i_rx_framer
    (
        .clk_50         (clk_50),
        .rst            (rst),
        .sample_en      (sample_en),
        .uart_rx        (uart_rx),
        .rx_vld         (rx_vld),
        .rx_data        (rx_data),
        .rx_frame_error (rx_frame_error),
        .frame_errors   (frame_errors)
    );

    // bad frames are discarded here and only show up in the error count.
    uart_byte_fifo #(.DEPTH(RX_DEPTH)) i_rx_fifo
    (
        .clk_50    (clk_50),
        .rst       (rst),
        .push      (rx_vld && !rx_frame_error),
        .push_data (rx_data),
        .pop       (rd_en && !rx_empty),
        .head      (rd_data),
        .empty     (rx_empty),
        .full      ()
    );

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
// UART package with the oversampling constant, the default divider and framer states.
`default_nettype none

package uart_pkg;

    // each bit cell is sampled seven times. The start patterns depend on it.
    localparam logic [2:0] samples_per_bit = 3'd7;

    // 50 MHz / (115200 * 7) rounds to 62 clocks per sample strobe.
    localparam int default_sample_div = 62;

    typedef enum logic [1:0]
    {
        rx_idle,
        rx_shift,
        rx_check
    } rx_state_t;

    typedef enum logic
    {
        tx_idle,
        tx_send
    } tx_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx_framer.sv
// UART receive framer: start detection, two-sample bit votes, frame check and error count.
`default_nettype none

module uart_rx_framer
(
    input  wire logic       clk_50,
    input  wire logic       rst,
    input  wire logic       sample_en,
    input  wire logic       uart_rx,
    output logic            rx_vld,
    output logic [7:0]      rx_data,
    output logic            rx_frame_error,
    output logic [7:0]      frame_errors
);

    import uart_pkg::*;

    rx_state_t  state;
    logic [6:0] rx_sample;
    logic [2:0] cell_cnt;
    logic [3:0] bit_cnt;
    logic [8:0] rx_capture;
    logic [8:0] rx_bit_err;
    logic       rx_falling_clean;
    logic       rx_falling_tolerant;
    logic       rx_falling;
    logic       vote_high;
    logic       vote_low;
    logic       cell_end;

    // newest sample sits in bit 0 of the history.
    assign rx_falling_clean    = (rx_sample == 7'b1110000);
    assign rx_falling_tolerant = (rx_sample[6:4] == 3'b110) && (rx_sample[1:0] == 2'b00);
    assign rx_falling          = rx_falling_clean || rx_falling_tolerant;

    // when a cell count wraps, the two newest samples are the middle of that bit.
    assign vote_high = (rx_sample[1:0] == 2'b11);
    assign vote_low  = (rx_sample[1:0] == 2'b00);
    assign cell_end  = sample_en && (cell_cnt == samples_per_bit - 3'd1);

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
            rx_sample <= '1; // an idle line is high.
        else if (sample_en)
            rx_sample <= {rx_sample[5:0], uart_rx};
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            state    <= rx_idle;
            cell_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            case (state)
                rx_idle:
                begin
                    cell_cnt <= '0;
                    bit_cnt  <= '0;
                    if (sample_en && rx_falling)
                        state <= rx_shift;
                end
                rx_shift:
                begin
                    if (cell_end)
                    begin
                        cell_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd8) // stop bit decided.
                            state <= rx_check;
                    end
                    else if (sample_en)
                        cell_cnt <= cell_cnt + 3'd1;
                end
                rx_check:
                    state <= rx_idle;
                default:
                    state <= rx_idle;
            endcase
        end
    end

    // eight data bits, msb first, then the stop bit end up in the capture register.
    always_ff @(posedge clk_50)
    begin
        if ((state == rx_shift) && cell_end)
        begin
            rx_capture <= {rx_capture[7:0], vote_high};
            rx_bit_err <= {rx_bit_err[7:0], !vote_high && !vote_low}; // split vote.
        end
    end

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
            frame_errors <= '0;
        else if (rx_vld && rx_frame_error && (frame_errors != 8'hff))
            frame_errors <= frame_errors + 8'd1;
    end

    assign rx_vld         = (state == rx_check);
    assign rx_data        = rx_capture[8:1];
    assign rx_frame_error = (rx_bit_err != 9'd0) || !rx_capture[0];

endmodule

`default_nettype wire

//--- rtl/uart_sample_tick.sv
// UART sample tick: divides clk_50 into a one-cycle strobe at seven times the bit rate.
`default_nettype none

module uart_sample_tick
#(
    parameter int SAMPLE_DIV = uart_pkg::default_sample_div
)
(
    input  wire logic clk_50,
    input  wire logic rst,
    output logic      sample_en
);

    localparam int cnt_w = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [cnt_w-1:0] div_cnt;

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            sample_en <= 1'b0;
        end
        else if (div_cnt == cnt_w'(SAMPLE_DIV - 1))
        begin
            div_cnt   <= '0;
            sample_en <= 1'b1; // both framers run off this one strobe.
        end
        else
        begin
            div_cnt   <= div_cnt + 1'b1;
            sample_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx_framer.sv
// UART transmit framer: sends start, eight data bits msb first and stop, seven strobes per bit.
`default_nettype none

module uart_tx_framer
(
    input  wire logic       clk_50,
    input  wire logic       rst,
    input  wire logic       sample_en,
    input  wire logic       tx_empty,
    input  wire logic [7:0] tx_byte,
    output logic            tx_pop,
    output logic            uart_tx
);

    import uart_pkg::*;

    tx_state_t  state;
    logic [9:0] tx_shift;
    logic [2:0] cell_cnt;
    logic [3:0] bit_cnt;
    logic       cell_end;

    assign tx_pop   = (state == tx_idle) && !tx_empty; // load and pop in one cycle.
    assign uart_tx  = tx_shift[9];
    assign cell_end = sample_en && (cell_cnt == samples_per_bit - 3'd1);

    always_ff @(posedge clk_50 or posedge rst)
    begin
        if (rst)
        begin
            state    <= tx_idle;
            tx_shift <= '1;
            cell_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            case (state)
                tx_idle:
                begin
                    cell_cnt <= '0;
                    bit_cnt  <= '0;
                    if (tx_pop)
                    begin
                        state    <= tx_send;
                        tx_shift <= {1'b0, tx_byte, 1'b1}; // start, data, stop.
                    end
                end
                tx_send:
                begin
                    if (cell_end)
                    begin
                        cell_cnt <= '0;
                        tx_shift <= {tx_shift[8:0], 1'b1};
                        bit_cnt  <= bit_cnt + 4'd1;
                        // the stop cell has just finished.
                        if (bit_cnt == 4'd9)
                            state <= tx_idle;
                    end
                    else if (sample_en)
                        cell_cnt <= cell_cnt + 3'd1;
                end
                default:
                    state <= tx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_uart_core.sv
// UART core testbench: directed loopback, burst, back-pressure and framing error tests.
`default_nettype none

module tb_uart_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sample_div   = 62;
    localparam int bit_cycles   = 7 * sample_div;
    localparam int frame_cycles = 10 * bit_cycles;
    localparam int wait_limit   = 3 * frame_cycles;
    localparam int cycle_limit  = 120000; // about 13 frames plus margin.

    logic       clk_50;
    logic       rst;
    logic       wr_en;
    logic [7:0] wr_data;
    logic       tx_full;
    logic       rd_en;
    logic [7:0] rd_data;
    logic       rx_empty;
    logic [7:0] frame_errors;
    logic       uart_tx;
    logic       uart_rx;
    logic       loop_sel;
    logic       line_tx;
    logic [7:0] pattern [6];
    int         error_count;
    int         check_count;
    int         cycle_count;
    integer     seed;

    // loop_sel high feeds the transmitter straight back into the receiver.
    assign uart_rx = loop_sel ? uart_tx : line_tx;

    uart_core #(.SAMPLE_DIV(sample_div), .TX_DEPTH(4), .RX_DEPTH(8)) i_dut
    (
        .clk_50       (clk_50),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .tx_full      (tx_full),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .rx_empty     (rx_empty),
        .frame_errors (frame_errors),
        .uart_tx      (uart_tx),
        .uart_rx      (uart_rx)
    );

    initial
    begin
        clk_50 = 1'b0;
        forever #4 clk_50 = ~clk_50;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk_50);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("error: %s expected %h, got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_50);
    endtask

    task automatic write_byte(input logic [7:0] data);
        @(negedge clk_50);
        wr_en   = 1'b1;
        wr_data = data;
        @(negedge clk_50);
        wr_en   = 1'b0;
    endtask

    // waits for the next received byte, checks it and pops it.
    task automatic receive_byte(input logic [7:0] expected);
        int waited;
        waited = 0;
        @(negedge clk_50);
        while (rx_empty && (waited < wait_limit))
        begin
            @(negedge clk_50);
            waited++;
        end
        if (rx_empty)
        begin
            $display("no byte received while waiting for %h", expected);
            error_count++;
        end
        else
        begin
            check_value("rd_data", expected, rd_data);
            rd_en = 1'b1;
            @(negedge clk_50);
            rd_en = 1'b0;
        end
    endtask

    // line model: start, data msb first, stop, then one idle cell.
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        int         i;
        frame = {1'b0, data, stop_bit};
        for (i = 9; i >= 0; i--)
        begin
            @(negedge clk_50);
            line_tx = frame[i];
            wait_cycles(bit_cycles - 1);
        end
        @(negedge clk_50);
        line_tx = 1'b1;
        wait_cycles(bit_cycles - 1);
    endtask

    task automatic test_reset_state();
        check_value("uart_tx", 8'h01, {7'd0, uart_tx});
        check_value("rx_empty", 8'h01, {7'd0, rx_empty});
        check_value("tx_full", 8'h00, {7'd0, tx_full});
        check_value("frame_errors", 8'h00, frame_errors);
    endtask

    task automatic test_single_loopback();
        logic [7:0] data;
        data = random_byte();
        write_byte(data);
        receive_byte(data);
        check_value("rx_empty", 8'h01, {7'd0, rx_empty});
    endtask

    task automatic test_burst_order();
        int i;
        wait_cycles(2 * bit_cycles); // let the transmitter finish its stop cell.
        for (i = 0; i < 4; i++)
            pattern[i] = random_byte();
        for (i = 0; i < 4; i++)
        begin
            @(negedge clk_50);
            wr_en   = 1'b1;
            wr_data = pattern[i];
        end
        @(negedge clk_50);
        wr_en = 1'b0;
        for (i = 0; i < 4; i++)
            receive_byte(pattern[i]);
    endtask

    task automatic test_back_pressure();
        int i;
        wait_cycles(2 * bit_cycles);
        for (i = 0; i < 6; i++)
            pattern[i] = random_byte();
        for (i = 0; i < 6; i++)
        begin
            @(negedge clk_50);
            if (i == 4)
                check_value("tx_full", 8'h00, {7'd0, tx_full});
            if (i == 5)
                check_value("tx_full", 8'h01, {7'd0, tx_full}); // this write is lost.
            wr_en   = 1'b1;
            wr_data = pattern[i];
        end
        @(negedge clk_50);
        wr_en = 1'b0;
        for (i = 0; i < 5; i++)
            receive_byte(pattern[i]);
        wait_cycles(frame_cycles + bit_cycles);
        check_value("rx_empty", 8'h01, {7'd0, rx_empty});
    endtask

    task automatic test_framing_error();
        logic [7:0] data;
        @(negedge clk_50);
        loop_sel = 1'b0;
        // the last data bit is 0, so the low stop bit cannot look like a new start.
        send_frame(8'ha4, 1'b0);
        check_value("frame_errors", 8'h01, frame_errors);
        check_value("rx_empty", 8'h01, {7'd0, rx_empty});
        data = random_byte();
        send_frame(data, 1'b1);
        receive_byte(data);
        check_value("frame_errors", 8'h01, frame_errors);
        loop_sel = 1'b1;
    endtask

    initial
    begin
        seed        = 32'h6f9;
        error_count = 0;
        check_count = 0;
        rst         = 1'b1;
        wr_en       = 1'b0;
        wr_data     = 8'h00;
        rd_en       = 1'b0;
        loop_sel    = 1'b1;
        line_tx     = 1'b1;
        repeat (2) @(negedge clk_50);
        rst = 1'b0;

        test_reset_state();
        test_single_loopback();
        test_burst_order();
        test_back_pressure();
        test_framing_error();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_core.f
rtl/uart_pkg.sv
rtl/uart_sample_tick.sv
rtl/uart_byte_fifo.sv
rtl/uart_tx_framer.sv
rtl/uart_rx_framer.sv
rtl/uart_core.sv
sim/tb_uart_core.sv
